//--- src/tapnw_pkg.sv
// Package with the TAP state type, instruction codes, register widths, child count and ID codes
package tapnw_pkg;

   // ----------------------------------------------------------------------
   // TAP controller states
   // ----------------------------------------------------------------------
   // Encoding follows the usual 1149.1 state assignment
   typedef enum logic [3:0] {
      ST_EXIT2_DR = 4'h0,
      ST_EXIT1_DR = 4'h1,
      ST_SHIFT_DR = 4'h2,
      ST_PAUSE_DR = 4'h3,
      ST_SEL_IR   = 4'h4,
      ST_UPD_DR   = 4'h5,
      ST_CAP_DR   = 4'h6,
      ST_SEL_DR   = 4'h7,
      ST_EXIT2_IR = 4'h8,
      ST_EXIT1_IR = 4'h9,
      ST_SHIFT_IR = 4'hA,
      ST_PAUSE_IR = 4'hB,
      ST_RTI      = 4'hC,
      ST_UPD_IR   = 4'hD,
      ST_CAP_IR   = 4'hE,
      ST_TLR      = 4'hF
   } tap_state_t;

   // ----------------------------------------------------------------------
   // Instruction register
   // ----------------------------------------------------------------------
   localparam int IR_WIDTH = 4;
   // Fixed pattern loaded in Capture-IR
   localparam logic [IR_WIDTH-1:0] IR_CAPTURE   = 4'b0001;
   localparam logic [IR_WIDTH-1:0] INSTR_IDCODE = 4'h2;
   localparam logic [IR_WIDTH-1:0] INSTR_SELECT = 4'h8;
   localparam logic [IR_WIDTH-1:0] INSTR_BYPASS = 4'hF;

   // ----------------------------------------------------------------------
   // Data registers and network size
   // ----------------------------------------------------------------------
   localparam int ID_WIDTH = 32;
   localparam logic [ID_WIDTH-1:0] CTL_IDCODE       = 32'h1A5E_0001;
   // Child index is added in bits 15:12
   localparam logic [ID_WIDTH-1:0] STAP_IDCODE_BASE = 32'h2B60_0001;
   // Number of children and width of the select register
   localparam int NUM_STAPS = 3;

endpackage

//--- src/tapnw_fsm.sv
// TAP controller state machine with decoded state strobes
`timescale 1ns/1ns

module tapnw_fsm import tapnw_pkg::*; (
   input  logic       tck,
   input  logic       arst_n,
   input  logic       ce,
   input  logic       park,
   input  logic       tms,
   output tap_state_t state,
   output logic       capture_dr,
   output logic       shift_dr,
   output logic       update_dr,
   output logic       capture_ir,
   output logic       shift_ir,
   output logic       update_ir,
   output logic       test_logic_reset
);

   tap_state_t state_nxt;

   // ----------------------------------------------------------------------
   // Next state from tms
   // ----------------------------------------------------------------------
   always_comb begin
      case (state)
         ST_TLR:      state_nxt = tms ? ST_TLR      : ST_RTI;
         ST_RTI:      state_nxt = tms ? ST_SEL_DR   : ST_RTI;
         ST_SEL_DR:   state_nxt = tms ? ST_SEL_IR   : ST_CAP_DR;
         ST_CAP_DR:   state_nxt = tms ? ST_EXIT1_DR : ST_SHIFT_DR;
         ST_SHIFT_DR: state_nxt = tms ? ST_EXIT1_DR : ST_SHIFT_DR;
         ST_EXIT1_DR: state_nxt = tms ? ST_UPD_DR   : ST_PAUSE_DR;
         ST_PAUSE_DR: state_nxt = tms ? ST_EXIT2_DR : ST_PAUSE_DR;
         ST_EXIT2_DR: state_nxt = tms ? ST_UPD_DR   : ST_SHIFT_DR;
         ST_UPD_DR:   state_nxt = tms ? ST_SEL_DR   : ST_RTI;
         // Select-IR with tms high falls back to reset
         ST_SEL_IR:   state_nxt = tms ? ST_TLR      : ST_CAP_IR;
         ST_CAP_IR:   state_nxt = tms ? ST_EXIT1_IR : ST_SHIFT_IR;
         ST_SHIFT_IR: state_nxt = tms ? ST_EXIT1_IR : ST_SHIFT_IR;
         ST_EXIT1_IR: state_nxt = tms ? ST_UPD_IR   : ST_PAUSE_IR;
         ST_PAUSE_IR: state_nxt = tms ? ST_EXIT2_IR : ST_PAUSE_IR;
         ST_EXIT2_IR: state_nxt = tms ? ST_UPD_IR   : ST_SHIFT_IR;
         ST_UPD_IR:   state_nxt = tms ? ST_SEL_DR   : ST_RTI;
         default:     state_nxt = ST_TLR;
      endcase
   end

   // State register
   // Park wins over the clock enable and pins the controller in reset
   always_ff @(posedge tck or negedge arst_n) begin
      if (!arst_n) begin
         state <= ST_TLR;
      end else if (park) begin
         state <= ST_TLR;
      end else if (ce) begin
         state <= state_nxt;
      end
   end

   // ----------------------------------------------------------------------
   // State strobes for the register logic
   // ----------------------------------------------------------------------
   assign capture_dr       = (state == ST_CAP_DR);
   assign shift_dr         = (state == ST_SHIFT_DR);
   assign update_dr        = (state == ST_UPD_DR);
   assign capture_ir       = (state == ST_CAP_IR);
   assign shift_ir         = (state == ST_SHIFT_IR);
   assign update_ir        = (state == ST_UPD_IR);
   assign test_logic_reset = (state == ST_TLR);

endmodule

//--- src/tapnw_ctl_tap.sv
// Control TAP with instruction register, IDCODE, BYPASS and network select register
`timescale 1ns/1ns

module tapnw_ctl_tap import tapnw_pkg::*; (
   input  logic                 tck,
   input  logic                 arst_n,
   input  logic                 tms,
   input  logic                 tdi,
   output logic [NUM_STAPS-1:0] sel,
   output logic                 ctl_so,
   output logic                 shifting
);

   tap_state_t          state;
   logic                capture_dr;
   logic                shift_dr;
   logic                update_dr;
   logic                capture_ir;
   logic                shift_ir;
   logic                update_ir;
   logic                test_logic_reset;
   logic [IR_WIDTH-1:0] ir_sr;
   logic [IR_WIDTH-1:0] ir;
   logic [ID_WIDTH-1:0] id_sr;
   logic                byp;
   logic [NUM_STAPS-1:0] sel_sr;
   logic                id_instr;
   logic                sel_instr;
   logic                byp_instr;

   // Control TAP always runs and is never parked
   tapnw_fsm fsm_i (
      .tck              (tck),
      .arst_n           (arst_n),
      .ce               (1'b1),
      .park             (1'b0),
      .tms              (tms),
      .state            (state),
      .capture_dr       (capture_dr),
      .shift_dr         (shift_dr),
      .update_dr        (update_dr),
      .capture_ir       (capture_ir),
      .shift_ir         (shift_ir),
      .update_ir        (update_ir),
      .test_logic_reset (test_logic_reset)
   );

   // ----------------------------------------------------------------------
   // Instruction register
   // ----------------------------------------------------------------------
   always_ff @(posedge tck) begin
      if (capture_ir) begin
         ir_sr <= IR_CAPTURE;
      end else if (shift_ir) begin
         ir_sr <= {tdi, ir_sr[IR_WIDTH-1:1]};
      end
   end

   // Instruction in force, back to IDCODE in Test-Logic-Reset
   always_ff @(posedge tck or negedge arst_n) begin
      if (!arst_n) begin
         ir <= INSTR_IDCODE;
      end else if (test_logic_reset) begin
         ir <= INSTR_IDCODE;
      end else if (update_ir) begin
         ir <= ir_sr;
      end
   end

   // Unknown codes fall to BYPASS
   assign id_instr  = (ir == INSTR_IDCODE);
   assign sel_instr = (ir == INSTR_SELECT);
   assign byp_instr = !id_instr && !sel_instr;

   // ----------------------------------------------------------------------
   // Data registers
   // ----------------------------------------------------------------------
   always_ff @(posedge tck) begin
      if (capture_dr && id_instr) begin
         id_sr <= CTL_IDCODE;
      end else if (shift_dr && id_instr) begin
         id_sr <= {tdi, id_sr[ID_WIDTH-1:1]};
      end
   end

   // Bypass bit captures zero
   always_ff @(posedge tck) begin
      if (capture_dr && byp_instr) begin
         byp <= 1'b0;
      end else if (shift_dr && byp_instr) begin
         byp <= tdi;
      end
   end

   // Select shift stage reads back the present select
   always_ff @(posedge tck) begin
      if (capture_dr && sel_instr) begin
         sel_sr <= sel;
      end else if (shift_dr && sel_instr) begin
         sel_sr <= {tdi, sel_sr[NUM_STAPS-1:1]};
      end
   end

   // Select update register, all children parked after reset
   always_ff @(posedge tck or negedge arst_n) begin
      if (!arst_n) begin
         sel <= '0;
      end else if (test_logic_reset) begin
         sel <= '0;
      end else if (update_dr && sel_instr) begin
         sel <= sel_sr;
      end
   end

   // Serial out from the register picked by the current instruction
   always_comb begin
      if (state == ST_SHIFT_IR) begin
         ctl_so = ir_sr[0];
      end else if (id_instr) begin
         ctl_so = id_sr[0];
      end else if (sel_instr) begin
         ctl_so = sel_sr[0];
      end else begin
         ctl_so = byp;
      end
   end

   assign shifting = (state == ST_SHIFT_DR) || (state == ST_SHIFT_IR);

endmodule

//--- src/tapnw_stap.sv
// Child TAP with state machine, instruction register, IDCODE, BYPASS and park control
`timescale 1ns/1ns

module tapnw_stap import tapnw_pkg::*; #(
   parameter int IDX = 0
) (
   input  logic tck,
   input  logic arst_n,
   input  logic st_tms,
   input  logic st_ce,
   input  logic st_park,
   input  logic st_tdi,
   output logic st_so
);

   // Child identification carries the index in bits 15:12
   localparam logic [ID_WIDTH-1:0] CHILD_IDCODE = STAP_IDCODE_BASE + (ID_WIDTH'(IDX) << 12);

   tap_state_t          state;
   logic                capture_dr;
   logic                shift_dr;
   logic                capture_ir;
   logic                shift_ir;
   logic                update_ir;
   logic                test_logic_reset;
   logic [IR_WIDTH-1:0] ir_sr;
   logic [IR_WIDTH-1:0] ir;
   logic [ID_WIDTH-1:0] id_sr;
   logic                byp;
   logic                id_instr;

   // No shadow data register here, so Update-DR has no use
   tapnw_fsm fsm_i (
      .tck              (tck),
      .arst_n           (arst_n),
      .ce               (st_ce),
      .park             (st_park),
      .tms              (st_tms),
      .state            (state),
      .capture_dr       (capture_dr),
      .shift_dr         (shift_dr),
      .update_dr        (),
      .capture_ir       (capture_ir),
      .shift_ir         (shift_ir),
      .update_ir        (update_ir),
      .test_logic_reset (test_logic_reset)
   );

   // ----------------------------------------------------------------------
   // Instruction register
   // ----------------------------------------------------------------------
   always_ff @(posedge tck) begin
      if (st_ce && capture_ir) begin
         ir_sr <= IR_CAPTURE;
      end else if (st_ce && shift_ir) begin
         ir_sr <= {st_tdi, ir_sr[IR_WIDTH-1:1]};
      end
   end

   // Parked children sit in reset and keep IDCODE
   always_ff @(posedge tck or negedge arst_n) begin
      if (!arst_n) begin
         ir <= INSTR_IDCODE;
      end else if (test_logic_reset) begin
         ir <= INSTR_IDCODE;
      end else if (st_ce && update_ir) begin
         ir <= ir_sr;
      end
   end

   // Anything but IDCODE acts as BYPASS
   assign id_instr = (ir == INSTR_IDCODE);

   // ----------------------------------------------------------------------
   // Data registers
   // ----------------------------------------------------------------------
   always_ff @(posedge tck) begin
      if (st_ce && id_instr) begin
         if (capture_dr) begin
            id_sr <= CHILD_IDCODE;
         end else if (shift_dr) begin
            id_sr <= {st_tdi, id_sr[ID_WIDTH-1:1]};
         end
      end
   end

   always_ff @(posedge tck) begin
      if (st_ce && !id_instr) begin
         if (capture_dr) begin
            byp <= 1'b0;
         end else if (shift_dr) begin
            byp <= st_tdi;
         end
      end
   end

   // Serial out toward the next TAP in the chain
   assign st_so = (state == ST_SHIFT_IR) ? ir_sr[0] : (id_instr ? id_sr[0] : byp);

endmodule

//--- src/tapnw_chain.sv
// Scan chain router with per-child tdi steering, tdo mux, tms gating and clock enables
`timescale 1ns/1ns

module tapnw_chain import tapnw_pkg::*; (
   input  logic                 tms,
   input  logic                 tdi,
   input  logic [NUM_STAPS-1:0] sel,
   input  logic                 ctl_so,
   input  logic                 shifting,
   input  logic [NUM_STAPS-1:0] st_so,
   output logic [NUM_STAPS-1:0] st_tms,
   output logic [NUM_STAPS-1:0] st_ce,
   output logic [NUM_STAPS-1:0] st_park,
   output logic [NUM_STAPS-1:0] st_tdi,
   output logic                 tdo,
   output logic                 tdo_en
);

   // Serial data running down the chain during the scan below
   logic link;

   // ----------------------------------------------------------------------
   // Park control
   // ----------------------------------------------------------------------
   // Parked children see tms high so they stay in reset
   assign st_tms  = {NUM_STAPS{tms}} | ~sel;
   assign st_ce   = sel;
   assign st_park = ~sel;

   // ----------------------------------------------------------------------
   // Chain order
   // ----------------------------------------------------------------------
   // Walk upward from the control TAP
   // each enabled child takes the latest upstream output
   always_comb begin
      link = ctl_so;
      for (int i = 0; i < NUM_STAPS; i++) begin
         if (sel[i]) begin
            st_tdi[i] = link;
            link      = st_so[i];
         end else begin
            // Raw tdi here is ignored while the child is parked
            st_tdi[i] = tdi;
         end
      end
      // Whatever is left is the chain tail
      tdo = link;
   end

   // Output driver enabled only in shift states
   assign tdo_en = shifting;

endmodule

//--- src/tapnw_top.sv
// Top level with the control TAP, chain router and child TAPs
`timescale 1ns/1ns

module tapnw_top import tapnw_pkg::*; (
   input  logic tck,
   input  logic arst_n,
   input  logic tms,
   input  logic tdi,
   output logic tdo,
   output logic tdo_en
);

   logic [NUM_STAPS-1:0] sel;
   logic                 ctl_so;
   logic                 shifting;
   logic [NUM_STAPS-1:0] st_tms;
   logic [NUM_STAPS-1:0] st_ce;
   logic [NUM_STAPS-1:0] st_park;
   logic [NUM_STAPS-1:0] st_tdi;
   logic [NUM_STAPS-1:0] st_so;

   // ----------------------------------------------------------------------
   // Control TAP at the head of the chain
   // ----------------------------------------------------------------------
   tapnw_ctl_tap ctl_i (
      .tck      (tck),
      .arst_n   (arst_n),
      .tms      (tms),
      .tdi      (tdi),
      .sel      (sel),
      .ctl_so   (ctl_so),
      .shifting (shifting)
   );

   // Chain router
   tapnw_chain chain_i (
      .tms      (tms),
      .tdi      (tdi),
      .sel      (sel),
      .ctl_so   (ctl_so),
      .shifting (shifting),
      .st_so    (st_so),
      .st_tms   (st_tms),
      .st_ce    (st_ce),
      .st_park  (st_park),
      .st_tdi   (st_tdi),
      .tdo      (tdo),
      .tdo_en   (tdo_en)
   );

   // ----------------------------------------------------------------------
   // Child TAPs, index sets the IDCODE
   // ----------------------------------------------------------------------
   for (genvar i = 0; i < NUM_STAPS; i++) begin : stap_g
      tapnw_stap #(
         .IDX (i)
      ) stap_i (
         .tck     (tck),
         .arst_n  (arst_n),
         .st_tms  (st_tms[i]),
         .st_ce   (st_ce[i]),
         .st_park (st_park[i]),
         .st_tdi  (st_tdi[i]),
         .st_so   (st_so[i])
      );
   end

endmodule

//--- bench/tapnw_tb.sv
// Testbench with clock, reset, LCG stimulus, TAP chain model, checks and watchdog
`timescale 1ns/1ns

module tapnw_tb import tapnw_pkg::*; ();

   localparam int TCK_PERIOD      = 8;
   localparam int ITERATIONS      = 40;
   localparam int CYCLES_PER_ITER = 400;
   localparam int WATCHDOG_NS     = ITERATIONS * CYCLES_PER_ITER * TCK_PERIOD;
   // Control TAP at index 0, child i at index i + 1
   localparam int NUM_TAPS        = NUM_STAPS + 1;
   localparam int MAX_BITS        = 256;

   logic                 tck = 1'b0;
   logic                 arst_n;
   logic                 tms;
   logic                 tdi;
   logic                 tdo;
   logic                 tdo_en;

   logic [31:0]          lcg_state;
   tap_state_t           state_model;
   logic [NUM_STAPS-1:0] sel_model;
   logic [IR_WIDTH-1:0]  ir_model [NUM_TAPS];
   // Values and lengths to shift into each TAP on a write scan
   logic [ID_WIDTH-1:0]  tap_val [NUM_TAPS];
   int                   tap_len [NUM_TAPS];
   logic                 tdo_smp;
   int                   errors;

   always #(TCK_PERIOD / 2) tck = ~tck;

   tapnw_top dut_i (
      .tck    (tck),
      .arst_n (arst_n),
      .tms    (tms),
      .tdi    (tdi),
      .tdo    (tdo),
      .tdo_en (tdo_en)
   );

   // ----------------------------------------------------------------------
   // Random source and controller model
   // ----------------------------------------------------------------------
   function automatic logic [31:0] rand32();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic logic [MAX_BITS-1:0] rand_bits();
      logic [MAX_BITS-1:0] v;
      for (int w = 0; w < MAX_BITS / 32; w++) begin
         v[w*32 +: 32] = rand32();
      end
      return v;
   endfunction

   // Random code that neither TAP decodes as IDCODE or SELECT
   function automatic logic [IR_WIDTH-1:0] rand_bypass_code();
      logic [31:0]         r;
      logic [IR_WIDTH-1:0] code;
      r    = rand32();
      code = r[31 -: IR_WIDTH];
      if (code == INSTR_IDCODE || code == INSTR_SELECT) begin
         code = INSTR_BYPASS;
      end
      return code;
   endfunction

   // IEEE 1149.1 state transitions
   function automatic tap_state_t next_state(input tap_state_t s, input logic m);
      case (s)
         ST_TLR:      return m ? ST_TLR      : ST_RTI;
         ST_RTI:      return m ? ST_SEL_DR   : ST_RTI;
         ST_SEL_DR:   return m ? ST_SEL_IR   : ST_CAP_DR;
         ST_CAP_DR:   return m ? ST_EXIT1_DR : ST_SHIFT_DR;
         ST_SHIFT_DR: return m ? ST_EXIT1_DR : ST_SHIFT_DR;
         ST_EXIT1_DR: return m ? ST_UPD_DR   : ST_PAUSE_DR;
         ST_PAUSE_DR: return m ? ST_EXIT2_DR : ST_PAUSE_DR;
         ST_EXIT2_DR: return m ? ST_UPD_DR   : ST_SHIFT_DR;
         ST_UPD_DR:   return m ? ST_SEL_DR   : ST_RTI;
         ST_SEL_IR:   return m ? ST_TLR      : ST_CAP_IR;
         ST_CAP_IR:   return m ? ST_EXIT1_IR : ST_SHIFT_IR;
         ST_SHIFT_IR: return m ? ST_EXIT1_IR : ST_SHIFT_IR;
         ST_EXIT1_IR: return m ? ST_UPD_IR   : ST_PAUSE_IR;
         ST_PAUSE_IR: return m ? ST_EXIT2_IR : ST_PAUSE_IR;
         ST_EXIT2_IR: return m ? ST_UPD_IR   : ST_SHIFT_IR;
         default:     return m ? ST_SEL_DR   : ST_RTI;
      endcase
   endfunction

   // ----------------------------------------------------------------------
   // Chain model
   // ----------------------------------------------------------------------
   function automatic bit tap_enabled(input int t);
      if (t == 0) begin
         return 1'b1;
      end
      return sel_model[t - 1];
   endfunction

   // DR length under the instruction in force
   function automatic int dr_width(input int t);
      if (ir_model[t] == INSTR_IDCODE) begin
         return ID_WIDTH;
      end
      if (t == 0 && ir_model[t] == INSTR_SELECT) begin
         return NUM_STAPS;
      end
      return 1;
   endfunction

   function automatic logic [ID_WIDTH-1:0] dr_capture(input int t);
      logic [ID_WIDTH-1:0] id;
      if (ir_model[t] == INSTR_IDCODE) begin
         if (t == 0) begin
            return CTL_IDCODE;
         end
         // Child index sits in bits 15:12
         id        = STAP_IDCODE_BASE;
         id[15:12] = 4'(t - 1);
         return id;
      end
      if (t == 0 && ir_model[t] == INSTR_SELECT) begin
         return ID_WIDTH'(sel_model);
      end
      // Bypass bit
      return '0;
   endfunction

   // Chain image, bit 0 is the tail TAP's LSB and the control TAP's MSB is last
   // Captured values or the tap_val write values
   function automatic int chain_bits(input bit from_capture, input bit is_ir,
                                     output logic [MAX_BITS-1:0] vec);
      int                  pos;
      int                  len;
      logic [ID_WIDTH-1:0] val;
      pos = 0;
      vec = '0;
      for (int t = NUM_TAPS - 1; t >= 0; t--) begin
         if (tap_enabled(t)) begin
            if (!from_capture) begin
               len = tap_len[t];
               val = tap_val[t];
            end else if (is_ir) begin
               len = IR_WIDTH;
               val = ID_WIDTH'(IR_CAPTURE);
            end else begin
               len = dr_width(t);
               val = dr_capture(t);
            end
            for (int b = 0; b < len; b++) begin
               vec[pos] = val[b];
               pos++;
            end
         end
      end
      return pos;
   endfunction

   // ----------------------------------------------------------------------
   // Checks and JTAG sequencing
   // ----------------------------------------------------------------------
   task automatic check_bit(input logic got, input logic exp, input string what);
      assert (got === exp) else begin
         errors++;
         $display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
         $display("SIMULATION FAILED");
         $fatal(1, "stopped at the first mismatch");
      end
   endtask

   // One tck cycle, outputs sampled at the falling edge before the shift edge
   task automatic step(input logic tms_v, input logic tdi_v);
      logic en_exp;
      tms = tms_v;
      tdi = tdi_v;
      @(negedge tck);
      tdo_smp = tdo;
      en_exp  = (state_model == ST_SHIFT_DR) || (state_model == ST_SHIFT_IR);
      check_bit(tdo_en, en_exp, "tdo_en");
      @(posedge tck);
      #1;
      state_model = next_state(state_model, tms_v);
   endtask

   // IR or DR scan of n bits from Run-Test/Idle back to Run-Test/Idle
   task automatic scan(input bit is_ir, input logic [MAX_BITS-1:0] din, input int n);
      logic [MAX_BITS-1:0] cap;
      int                  total;
      logic                exp_bit;
      total = chain_bits(1'b1, is_ir, cap);
      step(1'b1, 1'b0);
      if (is_ir) begin
         step(1'b1, 1'b0);
      end
      step(1'b0, 1'b0);
      step(1'b0, 1'b0);
      for (int i = 0; i < n; i++) begin
         // Captured bits first, then tdi delayed by the chain length
         exp_bit = (i < total) ? cap[i] : din[i - total];
         step(i == n - 1, din[i]);
         check_bit(tdo_smp, exp_bit,
                   $sformatf("tdo bit %0d of %s scan", i, is_ir ? "IR" : "DR"));
      end
      // Exit1 to Update, then Run-Test/Idle
      step(1'b1, 1'b0);
      step(1'b0, 1'b0);
   endtask

   task automatic load_ir(input logic [IR_WIDTH-1:0] ctl_code, input bit child_rand);
      logic [MAX_BITS-1:0] din;
      int                  total;
      for (int t = 0; t < NUM_TAPS; t++) begin
         tap_len[t] = IR_WIDTH;
         tap_val[t] = (t == 0 || !child_rand) ? ID_WIDTH'(ctl_code)
                                              : ID_WIDTH'(rand_bypass_code());
      end
      total = chain_bits(1'b0, 1'b1, din);
      scan(1'b1, din, total);
      for (int t = 0; t < NUM_TAPS; t++) begin
         if (tap_enabled(t)) begin
            ir_model[t] = tap_val[t][IR_WIDTH-1:0];
         end
      end
   endtask

   // Writes sel through SELECT with the children in bypass
   task automatic write_sel(input logic [NUM_STAPS-1:0] new_sel);
      logic [MAX_BITS-1:0] din;
      int                  total;
      load_ir(INSTR_SELECT, 1'b1);
      tap_len[0] = NUM_STAPS;
      tap_val[0] = ID_WIDTH'(new_sel);
      for (int t = 1; t < NUM_TAPS; t++) begin
         tap_len[t] = 1;
         tap_val[t] = '0;
      end
      total = chain_bits(1'b0, 1'b0, din);
      scan(1'b0, din, total);
      sel_model = new_sel;
      // Parked children sit in reset with IDCODE
      for (int t = 1; t < NUM_TAPS; t++) begin
         if (!sel_model[t - 1]) begin
            ir_model[t] = INSTR_IDCODE;
         end
      end
      // Newly enabled children leave reset in step with the control TAP
      step(1'b0, 1'b0);
   endtask

   task automatic scan_dr_random(input int extra);
      logic [MAX_BITS-1:0] cap;
      int                  total;
      total = chain_bits(1'b1, 1'b0, cap);
      scan(1'b0, rand_bits(), total + extra);
   endtask

   // ----------------------------------------------------------------------
   // Test sequence
   // ----------------------------------------------------------------------
   initial begin
      logic [31:0] r;
      lcg_state   = 32'h9f06_b09c;
      errors      = 0;
      arst_n      = 1'b0;
      tms         = 1'b1;
      tdi         = 1'b0;
      state_model = ST_TLR;
      sel_model   = '0;
      for (int t = 0; t < NUM_TAPS; t++) begin
         ir_model[t] = INSTR_IDCODE;
      end
      repeat (10) @(posedge tck);
      #1;
      arst_n = 1'b1;
      step(1'b0, 1'b0);

      // Only the control TAP answers after reset
      scan_dr_random(8);

      for (int it = 0; it < ITERATIONS; it++) begin
         r = rand32();
         write_sel(r[31 -: NUM_STAPS]);
         load_ir(INSTR_IDCODE, 1'b0);
         scan_dr_random(8);
         load_ir(INSTR_BYPASS, 1'b1);
         scan_dr_random(16);
      end

      // Every child enabled so the reset below has a select to clear
      write_sel({NUM_STAPS{1'b1}});

      // Five tms-high cycles reach Test-Logic-Reset from anywhere
      repeat (5) step(1'b1, 1'b0);
      sel_model = '0;
      for (int t = 0; t < NUM_TAPS; t++) begin
         ir_model[t] = INSTR_IDCODE;
      end
      step(1'b0, 1'b0);
      scan_dr_random(8);

      if (errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

   // Watchdog sized from the iteration count
   initial begin
      #(WATCHDOG_NS);
      $display("Timeout: the test sequence did not finish within %0d ns", WATCHDOG_NS);
      $display("SIMULATION FAILED");
      $fatal(1, "watchdog expired");
   end

endmodule

//--- tap_network.f
src/tapnw_pkg.sv
src/tapnw_fsm.sv
src/tapnw_ctl_tap.sv
src/tapnw_stap.sv
src/tapnw_chain.sv
src/tapnw_top.sv
bench/tapnw_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the tap_network testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Mdir "$OBJ" --top-module tapnw_tb -f tap_network.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$OBJ/Vtapnw_tb" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if grep -q "^SIMULATION PASSED$" "$LOG"; then
   exit 0
else
   echo "Pass message not found in $LOG"
   exit 1
fi
